// ==== Makefile ====
TOP = tb_approx_mac

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f verilog.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== approx_mac_top.sv ====
`timescale 1ns/100ps

module approx_mac_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              instr_valid,
    input  mac_isa_pkg::mac_op_t              instr_op,
    input  logic [mac_data_pkg::DATA_W-1:0]   instr_data,
    output logic                              result_valid,
    output logic [mac_data_pkg::DATA_W-1:0]   result_data,
    output logic [mac_data_pkg::ACC_W-1:0]    acc_value
);

    import mac_isa_pkg::*;
    import mac_data_pkg::*;

    // decode to execute.
    logic               weight_load;
    logic               mac_en;
    logic               acc_clear;
    logic               emit;
    logic [DATA_W-1:0]  operand;

    // execute to result.
    logic               emit_out;
    logic [SHIFT_W-1:0] emit_shift;

    mac_decode i_mac_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_op    (instr_op),
        .instr_data  (instr_data),
        .weight_load (weight_load),
        .mac_en      (mac_en),
        .acc_clear   (acc_clear),
        .emit        (emit),
        .operand     (operand)
    );

    mac_execute i_mac_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_load (weight_load),
        .mac_en      (mac_en),
        .acc_clear   (acc_clear),
        .emit        (emit),
        .operand     (operand),
        .acc_value   (acc_value),
        .emit_out    (emit_out),
        .emit_shift  (emit_shift)
    );

    mac_result i_mac_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .emit_out     (emit_out),
        .emit_shift   (emit_shift),
        .acc_value    (acc_value),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

endmodule

// ==== approx_mul8.sv ====
`timescale 1ns/100ps

module approx_mul8 (
    input  logic [mac_data_pkg::DATA_W-1:0] x,
    input  logic [mac_data_pkg::DATA_W-1:0] y,
    output logic [mac_data_pkg::PROD_W-1:0] z
);

    import mac_data_pkg::*;

    // pp[i] is y gated by bit i of x.
    logic [DATA_W-1:0] pp [0:DATA_W-1];

    // sparse correction vectors that stand in for the four low partial products.
    logic [10:0] corr1;
    logic [10:0] corr2;
    logic [10:0] corr3;
    logic [10:0] corr4;
    logic [10:0] corr5;

    logic [PROD_W-1:0] high_sum;
    logic [PROD_W-1:0] corr_sum;

    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            pp[i] = y & {DATA_W{x[i]}};
        end
    end

    // ########################################################################
    // approximate low half
    // ########################################################################

    // only a handful of bit pairs from pp[0] to pp[3] survive.
    // each one is merged into a single bit at a fixed column.
    always_comb begin
        corr1     = '0;
        corr1[3]  = pp[0][3] ^ pp[1][2];
        corr1[5]  = pp[2][3] ^ pp[3][2];
        corr1[6]  = pp[0][6] & pp[1][5];
        corr1[7]  = pp[0][6] | pp[1][5];
        corr1[8]  = pp[1][7];
        corr1[9]  = pp[2][7] | pp[3][6];
        corr1[10] = pp[3][7];

        corr2    = '0;
        corr2[7] = pp[0][7] | pp[1][6];
        corr2[8] = pp[2][6] & pp[3][5];

        corr3    = '0;
        corr3[7] = pp[2][4] | pp[3][3];
        corr3[8] = pp[2][6] | pp[3][5];

        // the AND and the OR of the same pair give a carry-like weight.
        corr4    = '0;
        corr4[7] = pp[2][5] & pp[3][4];

        corr5    = '0;
        corr5[7] = pp[2][5] | pp[3][4];
    end

    // ########################################################################
    // exact high half and final sum
    // ########################################################################

    always_comb begin
        high_sum = PROD_W'({pp[4], 4'b0000})
                 + PROD_W'({pp[5], 5'b00000})
                 + PROD_W'({pp[6], 6'b000000})
                 + PROD_W'({pp[7], 7'b0000000});

        corr_sum = PROD_W'(corr1)
                 + PROD_W'(corr2)
                 + PROD_W'(corr3)
                 + PROD_W'(corr4)
                 + PROD_W'(corr5);
    end

    assign z = high_sum + corr_sum;

endmodule

// ==== mac_data_pkg.sv ====
package mac_data_pkg;

    // ########################################################################
    // data path widths
    // ########################################################################

    // activations, weights and emitted results are all unsigned bytes.
    localparam int DATA_W = 8;

    // full width of the approximate product.
    localparam int PROD_W = 16;

    // the accumulator has four guard bits above a single product.
    localparam int ACC_W = 20;

    // ########################################################################
    // saturation limits
    // ########################################################################

    // the accumulator sticks here instead of wrapping around.
    localparam logic [ACC_W-1:0] ACC_MAX = {ACC_W{1'b1}};

    // largest value that fits in a result byte.
    localparam logic [DATA_W-1:0] RES_MAX = 8'd255;

endpackage

// ==== mac_decode.sv ====
`timescale 1ns/100ps

module mac_decode (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              instr_valid,
    input  mac_isa_pkg::mac_op_t              instr_op,
    input  logic [mac_data_pkg::DATA_W-1:0]   instr_data,
    output logic                              weight_load,
    output logic                              mac_en,
    output logic                              acc_clear,
    output logic                              emit,
    output logic [mac_data_pkg::DATA_W-1:0]   operand
);

    import mac_isa_pkg::*;

    // ########################################################################
    // instruction register
    // ########################################################################

    // an instruction sampled at edge N shows up as a single strobe plus its
    // operand right after that edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_load <= 1'b0;
            mac_en      <= 1'b0;
            acc_clear   <= 1'b0;
            emit        <= 1'b0;
            operand     <= '0;
        end else begin
            weight_load <= instr_valid && (instr_op == OP_LOAD_WEIGHT);
            mac_en      <= instr_valid && (instr_op == OP_MAC);
            acc_clear   <= instr_valid && (instr_op == OP_CLEAR);
            emit        <= instr_valid && (instr_op == OP_EMIT);

            // the operand only moves with a valid instruction.
            if (instr_valid) begin
                operand <= instr_data;
            end
        end
    end

    // ########################################################################
    // checks
    // ########################################################################

    // execute relies on never seeing two operations in the same stage.
    a_strobe_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0({weight_load, mac_en, acc_clear, emit})
    ) else $error("mac_decode: more than one strobe active");

    // an undefined opcode would silently drop the instruction.
    a_op_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |-> !$isunknown(instr_op)
    ) else $error("mac_decode: unknown opcode bits with instr_valid");

endmodule

// ==== mac_execute.sv ====
`timescale 1ns/100ps

module mac_execute (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               weight_load,
    input  logic                               mac_en,
    input  logic                               acc_clear,
    input  logic                               emit,
    input  logic [mac_data_pkg::DATA_W-1:0]    operand,
    output logic [mac_data_pkg::ACC_W-1:0]     acc_value,
    output logic                               emit_out,
    output logic [mac_isa_pkg::SHIFT_W-1:0]    emit_shift
);

    import mac_isa_pkg::*;
    import mac_data_pkg::*;

    logic [DATA_W-1:0]  weight_q;
    logic [PROD_W-1:0]  product;

    // first stage, side by side with the registered product.
    logic [PROD_W-1:0]  prod_q;
    logic               mac_q;
    logic               clear_q;
    logic               emit_q;
    logic [SHIFT_W-1:0] shift_q;

    logic [ACC_W:0]     acc_sum;

    // ########################################################################
    // weight and multiplier
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weight_q <= '0;
        end else if (weight_load) begin
            weight_q <= operand;
        end
    end

    // the activation is x and the stored weight is y.
    approx_mul8 i_approx_mul8 (
        .x (operand),
        .y (weight_q),
        .z (product)
    );

    // ########################################################################
    // product stage
    // ########################################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_q  <= '0;
            mac_q   <= 1'b0;
            clear_q <= 1'b0;
            emit_q  <= 1'b0;
            shift_q <= '0;
        end else begin
            prod_q  <= product;
            mac_q   <= mac_en;
            clear_q <= acc_clear;
            emit_q  <= emit;
            shift_q <= operand[SHIFT_W-1:0];
        end
    end

    // ########################################################################
    // accumulator stage
    // ########################################################################

    // one extra bit catches the carry that triggers saturation.
    assign acc_sum = {1'b0, acc_value} + (ACC_W + 1)'(prod_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_value  <= '0;
            emit_out   <= 1'b0;
            emit_shift <= '0;
        end else begin
            if (clear_q) begin
                acc_value <= '0;
            end else if (mac_q) begin
                acc_value <= acc_sum[ACC_W] ? ACC_MAX : acc_sum[ACC_W-1:0];
            end

            // emit leaves together with the accumulator it has to report.
            emit_out   <= emit_q;
            emit_shift <= shift_q;
        end
    end

    // the accumulator only ever grows or sticks, except on a clear.
    a_acc_no_decrease : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$past(clear_q) |-> (acc_value >= $past(acc_value))
    ) else $error("mac_execute: accumulator decreased without clear");

endmodule

// ==== mac_isa_pkg.sv ====
package mac_isa_pkg;

    // ########################################################################
    // instruction fields
    // ########################################################################

    // width of the opcode field driven by the host.
    localparam int OP_W = 2;

    // an emit carries its right shift amount in the low bits of the data
    // field, so the accumulator can be scaled by up to 15 bit positions.
    localparam int SHIFT_W = 4;

    // ########################################################################
    // opcodes
    // ########################################################################

    // one instruction is issued per cycle while instr_valid is high.
    //   OP_LOAD_WEIGHT  the data field becomes the new weight.
    //   OP_MAC          activation times weight is added to the accumulator.
    //   OP_CLEAR        the accumulator returns to zero.
    //   OP_EMIT         the scaled and clamped accumulator is sent out.
    typedef enum logic [OP_W-1:0] {
        OP_LOAD_WEIGHT = 2'd0,
        OP_MAC         = 2'd1,
        OP_CLEAR       = 2'd2,
        OP_EMIT        = 2'd3
    } mac_op_t;

endpackage

// ==== mac_result.sv ====
`timescale 1ns/100ps

module mac_result (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               emit_out,
    input  logic [mac_isa_pkg::SHIFT_W-1:0]    emit_shift,
    input  logic [mac_data_pkg::ACC_W-1:0]     acc_value,
    output logic                               result_valid,
    output logic [mac_data_pkg::DATA_W-1:0]    result_data
);

    import mac_data_pkg::*;

    logic [ACC_W-1:0]  shifted;
    logic              overflow;
    logic [DATA_W-1:0] clamped;

    // ########################################################################
    // scale and clamp
    // ########################################################################

    assign shifted = acc_value >> emit_shift;

    // anything left above the result byte means the value does not fit.
    assign overflow = |shifted[ACC_W-1:DATA_W];
    assign clamped  = overflow ? RES_MAX : shifted[DATA_W-1:0];

    // ########################################################################
    // output register
    // ########################################################################

    // result_data holds the last emitted value between emits.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_data  <= '0;
        end else begin
            result_valid <= emit_out;
            if (emit_out) begin
                result_data <= clamped;
            end
        end
    end

    // the host must never see a result while the engine is in reset.
    a_quiet_in_reset : assert property (
        @(posedge clk)
        !rst_n |-> !result_valid
    ) else $error("mac_result: result_valid high during reset");

endmodule

// ==== tb_approx_mac.sv ====
`timescale 1ns/100ps

module tb_approx_mac;

    import mac_isa_pkg::*;
    import mac_data_pkg::*;

    // instruction slots per test, idle slots of the quiet test included.
    localparam int EXACT_SLOTS  = 8;
    localparam int RANDOM_SLOTS = 451;
    localparam int CLEAR_SLOTS  = 7;
    localparam int SAT_SLOTS    = 24;
    localparam int QUIET_SLOTS  = 12;
    localparam int MAX_CYCLES   = EXACT_SLOTS + RANDOM_SLOTS + CLEAR_SLOTS + SAT_SLOTS
                                + QUIET_SLOTS + 16 + 50;

    logic              clk;
    logic              rst_n;
    logic              instr_valid;
    mac_op_t           instr_op;
    logic [DATA_W-1:0] instr_data;
    logic              result_valid;
    logic [DATA_W-1:0] result_data;
    logic [ACC_W-1:0]  acc_value;

    int seed = 32'h6e337c5b;
    int cycle = 0;

    // reference model state.
    logic              exact_mode = 1'b0;
    logic [DATA_W-1:0] model_weight = '0;
    logic [ACC_W-1:0]  model_acc = '0;

    // expected values with the cycle of the edge that sampled their instruction.
    logic [DATA_W-1:0] res_val_q[$];
    int                res_issue_q[$];
    logic [ACC_W-1:0]  acc_val_q[$];
    int                acc_issue_q[$];

    logic              exp_valid = 1'b0;
    logic [DATA_W-1:0] exp_data = '0;
    logic [ACC_W-1:0]  exp_acc = '0;

    int    valid_errs = 0;
    int    data_errs = 0;
    int    acc_errs = 0;
    int    reset_errs = 0;
    int    errs_at_start = 0;
    int    tests_run = 0;
    int    failed_tests = 0;
    string test_name = "reset";

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    approx_mac_top i_approx_mac_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_op     (instr_op),
        .instr_data   (instr_data),
        .result_valid (result_valid),
        .result_data  (result_data),
        .acc_value    (acc_value)
    );

    // ########################################################################
    // reference model
    // ########################################################################

    function automatic logic pp_bit(input logic [DATA_W-1:0] x, input logic [DATA_W-1:0] y,
                                    input int i, input int j);
        return x[i] & y[j];
    endfunction

    function automatic logic [PROD_W-1:0] at_column(input logic b, input int col);
        return PROD_W'(b) << col;
    endfunction

    function automatic logic [PROD_W-1:0] approx_product(input logic [DATA_W-1:0] x,
                                                         input logic [DATA_W-1:0] y);
        logic [PROD_W-1:0] z;
        z = '0;
        // rows 4 to 7 are exact.
        for (int i = 4; i < DATA_W; i++) begin
            if (x[i]) begin
                z = z + (PROD_W'(y) << i);
            end
        end
        // rows 0 to 3 shrink to single-bit terms at fixed columns.
        z = z + at_column(pp_bit(x, y, 0, 3) ^ pp_bit(x, y, 1, 2), 3);
        z = z + at_column(pp_bit(x, y, 2, 3) ^ pp_bit(x, y, 3, 2), 5);
        z = z + at_column(pp_bit(x, y, 0, 6) & pp_bit(x, y, 1, 5), 6);
        z = z + at_column(pp_bit(x, y, 0, 6) | pp_bit(x, y, 1, 5), 7);
        z = z + at_column(pp_bit(x, y, 0, 7) | pp_bit(x, y, 1, 6), 7);
        z = z + at_column(pp_bit(x, y, 2, 4) | pp_bit(x, y, 3, 3), 7);
        z = z + at_column(pp_bit(x, y, 2, 5) & pp_bit(x, y, 3, 4), 7);
        z = z + at_column(pp_bit(x, y, 2, 5) | pp_bit(x, y, 3, 4), 7);
        z = z + at_column(pp_bit(x, y, 1, 7), 8);
        z = z + at_column(pp_bit(x, y, 2, 6) & pp_bit(x, y, 3, 5), 8);
        z = z + at_column(pp_bit(x, y, 2, 6) | pp_bit(x, y, 3, 5), 8);
        z = z + at_column(pp_bit(x, y, 2, 7) | pp_bit(x, y, 3, 6), 9);
        z = z + at_column(pp_bit(x, y, 3, 7), 10);
        return z;
    endfunction

    function automatic logic [DATA_W-1:0] scale_result(input logic [ACC_W-1:0] acc,
                                                       input logic [SHIFT_W-1:0] sh);
        logic [ACC_W-1:0] v;
        v = acc >> sh;
        if (v > ACC_W'(RES_MAX)) begin
            return RES_MAX;
        end else begin
            return v[DATA_W-1:0];
        end
    endfunction

    // ########################################################################
    // stimulus
    // ########################################################################

    // the model sees each instruction in issue order, as the engine must.
    task automatic issue_instr(input mac_op_t op, input logic [DATA_W-1:0] data);
        logic [PROD_W-1:0] prod;
        logic [ACC_W:0]    wide;
        @(posedge clk);
        #2;
        instr_valid = 1'b1;
        instr_op    = op;
        instr_data  = data;
        case (op)
            OP_LOAD_WEIGHT: begin
                model_weight = data;
            end
            OP_MAC: begin
                if (exact_mode) begin
                    prod = PROD_W'(data) * PROD_W'(model_weight);
                end else begin
                    prod = approx_product(data, model_weight);
                end
                wide      = (ACC_W + 1)'(model_acc) + (ACC_W + 1)'(prod);
                model_acc = (wide > (ACC_W + 1)'(ACC_MAX)) ? ACC_MAX : wide[ACC_W-1:0];
                acc_val_q.push_back(model_acc);
                acc_issue_q.push_back(cycle + 1);
            end
            OP_CLEAR: begin
                model_acc = '0;
                acc_val_q.push_back(model_acc);
                acc_issue_q.push_back(cycle + 1);
            end
            default: begin
                res_val_q.push_back(scale_result(model_acc, data[SHIFT_W-1:0]));
                res_issue_q.push_back(cycle + 1);
            end
        endcase
    endtask

    // opcode and data wander while instr_valid is low.
    task automatic idle_slot();
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
        instr_op    = mac_op_t'(2'($random(seed)));
        instr_data  = 8'($random(seed));
    endtask

    task automatic drain();
        idle_slot();
        while (res_val_q.size() > 0 || acc_val_q.size() > 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    function automatic int error_total();
        return valid_errs + data_errs + acc_errs + reset_errs;
    endfunction

    task automatic start_test(input string name);
        test_name     = name;
        errs_at_start = error_total();
    endtask

    task automatic finish_test();
        int n;
        drain();
        n = error_total() - errs_at_start;
        tests_run++;
        if (n > 0) begin
            failed_tests++;
            $display("%s: failed with %0d errors", test_name, n);
        end else begin
            $display("%s: passed", test_name);
        end
    endtask

    // ########################################################################
    // tests
    // ########################################################################

    task automatic run_exact_path();
        start_test("exact_path");
        exact_mode = 1'b1;
        issue_instr(OP_CLEAR, 8'd0);
        issue_instr(OP_LOAD_WEIGHT, 8'd2);
        issue_instr(OP_MAC, 8'd16);
        issue_instr(OP_MAC, 8'd32);
        issue_instr(OP_MAC, 8'd0);
        issue_instr(OP_MAC, 8'd48);
        issue_instr(OP_MAC, 8'd16);
        issue_instr(OP_EMIT, 8'd0);
        exact_mode = 1'b0;
        finish_test();
    endtask

    // clearing after each emit keeps the sums away from saturation.
    task automatic run_approx_path();
        start_test("approx_path");
        issue_instr(OP_CLEAR, 8'd0);
        for (int n = 1; n <= 200; n++) begin
            issue_instr(OP_LOAD_WEIGHT, 8'($random(seed)));
            issue_instr(OP_MAC, 8'($random(seed)));
            if (n % 8 == 0) begin
                issue_instr(OP_EMIT, 8'($random(seed)));
                issue_instr(OP_CLEAR, 8'd0);
            end
        end
        finish_test();
    endtask

    task automatic run_clear();
        start_test("clear");
        issue_instr(OP_LOAD_WEIGHT, 8'($random(seed)));
        issue_instr(OP_MAC, 8'($random(seed)));
        issue_instr(OP_MAC, 8'($random(seed)));
        issue_instr(OP_MAC, 8'($random(seed)));
        issue_instr(OP_EMIT, 8'd4);
        issue_instr(OP_CLEAR, 8'd0);
        issue_instr(OP_EMIT, 8'd0);
        finish_test();
    endtask

    task automatic run_saturation();
        start_test("saturation");
        issue_instr(OP_CLEAR, 8'd0);
        issue_instr(OP_LOAD_WEIGHT, 8'd255);
        repeat (20) issue_instr(OP_MAC, 8'd255);
        issue_instr(OP_EMIT, 8'd0);
        issue_instr(OP_EMIT, 8'd12);
        finish_test();
    endtask

    task automatic run_quiet();
        start_test("latency_quiet");
        repeat (4) idle_slot();
        issue_instr(OP_CLEAR, 8'd0);
        issue_instr(OP_LOAD_WEIGHT, 8'($random(seed)));
        issue_instr(OP_MAC, 8'($random(seed)));
        issue_instr(OP_EMIT, 8'($random(seed)));
        repeat (4) idle_slot();
        finish_test();
    endtask

    // ########################################################################
    // expected outputs and checks
    // ########################################################################

    // values are set up at the falling edge so the next rising edge sees them settled.
    always @(negedge clk) begin
        exp_valid = 1'b0;
        if (res_issue_q.size() > 0 && res_issue_q[0] + 3 == cycle) begin
            exp_valid = 1'b1;
            exp_data  = res_val_q.pop_front();
            void'(res_issue_q.pop_front());
        end
        if (acc_issue_q.size() > 0 && acc_issue_q[0] + 2 == cycle) begin
            exp_acc = acc_val_q.pop_front();
            void'(acc_issue_q.pop_front());
        end
    end

    a_result_timing : assert property (
        @(posedge clk) disable iff (!rst_n)
        result_valid == exp_valid
    ) else begin
        valid_errs++;
        if ($sampled(result_valid)) begin
            $display("%s: result_valid rose with no emit due in this cycle", test_name);
        end else begin
            $display("%s: result_valid stayed low for an emit that was due", test_name);
        end
    end

    a_result_data : assert property (
        @(posedge clk) disable iff (!rst_n)
        (result_valid && exp_valid) |-> (result_data == exp_data)
    ) else begin
        data_errs++;
        $display("[ERROR] %s: result_data expected %0d actual %0d",
                 test_name, $sampled(exp_data), $sampled(result_data));
    end

    a_acc_value : assert property (
        @(posedge clk) disable iff (!rst_n)
        acc_value == exp_acc
    ) else begin
        acc_errs++;
        $display("[ERROR] %s: acc_value expected %0d actual %0d",
                 test_name, $sampled(exp_acc), $sampled(acc_value));
    end

    a_quiet_reset : assert property (
        @(posedge clk)
        !rst_n |-> !result_valid
    ) else begin
        reset_errs++;
        $display("result_valid went high while reset was asserted");
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        instr_valid = 1'b0;
        instr_op    = OP_LOAD_WEIGHT;
        instr_data  = '0;
        wait (rst_n === 1'b1);
        run_exact_path();
        run_approx_path();
        run_clear();
        run_saturation();
        run_quiet();
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, failed_tests, error_total());
        if (error_total() == 0 && failed_tests == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset is released just after the 16th rising edge, like any other input.
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== verilog.f ====
mac_isa_pkg.sv
mac_data_pkg.sv
approx_mul8.sv
mac_decode.sv
mac_execute.sv
mac_result.sv
approx_mac_top.sv
tb_clock_gen.sv
tb_approx_mac.sv
